//--- all.f
+incdir+test
src/isaPkg.sv
src/pipePkg.sv
src/instrDecode.sv
src/regFile.sv
src/idExReg.sv
src/execStage.sv
src/pipeCore.sv
test/pipeCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= pipeCoreTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- test/progTable.svh
`ifndef PROG_TABLE_SVH
`define PROG_TABLE_SVH

    // ****************************************
    // Program and expected results
    // ****************************************

    localparam int          NUM_ROWS = 28;
    localparam logic [31:0] PC_BASE  = 32'h0000_0100;

    // Valid low marks an idle gap.
    typedef struct packed {
        logic        valid;
        logic [31:0] word;
        logic [31:0] pc;
        logic        wbValid;     // Expected two cycles after the strobe.
        logic [4:0]  wbReg;
        logic [31:0] wbData;
        logic        rdValid;     // Expected one cycle after the strobe.
        logic [31:0] rdTarget;
    } rowT;

    rowT prog [NUM_ROWS];

    function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(input opcodeT op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic expectWrite(input int n, input logic [31:0] w, input logic [4:0] rd,
                               input logic [31:0] data);
        prog[n] = '{1'b1, w, PC_BASE + 32'(n * 4), 1'b1, rd, data, 1'b0, 32'd0};
    endtask

    task automatic expectRedirect(input int n, input logic [31:0] w, input logic [31:0] target);
        prog[n] = '{1'b1, w, PC_BASE + 32'(n * 4), 1'b0, 5'd0, 32'd0, 1'b1, target};
    endtask

    task automatic expectNothing(input int n, input logic [31:0] w);
        prog[n] = '{1'b1, w, PC_BASE + 32'(n * 4), 1'b0, 5'd0, 32'd0, 1'b0, 32'd0};
    endtask

    task automatic idleSlot(input int n, input logic [31:0] w);
        prog[n] = '{1'b0, w, PC_BASE + 32'(n * 4), 1'b0, 5'd0, 32'd0, 1'b0, 32'd0};
    endtask

    task automatic fillTable();
        for (int n = 0; n < NUM_ROWS; n++) begin
            prog[n] = '0;
        end
        // Idle slots carry live words with valid low.
        idleSlot(0, iWord(OP_ADDI, 5'd31, 5'd0, 16'h0055));
        idleSlot(12, iWord(OP_BEQ, 5'd0, 5'd0, 16'd1));
        idleSlot(23, iWord(OP_ADDI, 5'd31, 5'd1, 16'd1));
        // ALU operations, forwarding and bypass.
        expectWrite(1, iWord(OP_ADDI, 5'd1, 5'd0, 16'd5), 5'd1, 32'd5);
        expectWrite(2, iWord(OP_ADDI, 5'd2, 5'd0, 16'hfffd), 5'd2, 32'hffff_fffd);
        expectWrite(3, rWord(FN_ADD, 5'd3, 5'd1, 5'd2), 5'd3, 32'd2);
        expectWrite(4, rWord(FN_SUB, 5'd4, 5'd3, 5'd1), 5'd4, 32'hffff_fffd);
        expectWrite(5, rWord(FN_AND, 5'd5, 5'd2, 5'd1), 5'd5, 32'd5);
        expectWrite(6, rWord(FN_OR, 5'd6, 5'd4, 5'd3), 5'd6, 32'hffff_ffff);
        expectWrite(7, rWord(FN_SLT, 5'd7, 5'd2, 5'd1), 5'd7, 32'd1);
        expectWrite(8, rWord(FN_SLT, 5'd8, 5'd1, 5'd2), 5'd8, 32'd0);
        expectWrite(9, iWord(OP_ORI, 5'd9, 5'd0, 16'h8001), 5'd9, 32'h0000_8001);
        expectWrite(10, iWord(OP_LUI, 5'd10, 5'd0, 16'habcd), 5'd10, 32'habcd_0000);
        expectWrite(11, iWord(OP_ORI, 5'd10, 5'd10, 16'h1234), 5'd10, 32'habcd_1234);
        // Writes to r0 are dropped.
        expectNothing(13, iWord(OP_ADDI, 5'd0, 5'd1, 16'd7));
        expectWrite(14, rWord(FN_ADD, 5'd11, 5'd0, 5'd1), 5'd11, 32'd5);
        // Taken branches kill the next slot.
        expectRedirect(15, iWord(OP_BEQ, 5'd5, 5'd1, 16'd3), 32'h0000_014c);
        expectNothing(16, iWord(OP_ADDI, 5'd12, 5'd0, 16'd99));
        expectNothing(17, iWord(OP_BNE, 5'd5, 5'd1, 16'd4));
        expectWrite(18, iWord(OP_ADDI, 5'd13, 5'd1, 16'd1), 5'd13, 32'd6);
        expectRedirect(19, iWord(OP_BNE, 5'd1, 5'd13, 16'hfffe), 32'h0000_0148);
        expectNothing(20, rWord(FN_SUB, 5'd14, 5'd13, 5'd1));
        expectNothing(21, iWord(OP_BEQ, 5'd8, 5'd3, 16'd1));
        expectWrite(22, rWord(FN_SUB, 5'd14, 5'd13, 5'd1), 5'd14, 32'd1);
        expectRedirect(24, iWord(OP_BEQ, 5'd0, 5'd0, 16'd2), 32'h0000_016c);
        expectWrite(26, rWord(FN_ADD, 5'd15, 5'd14, 5'd7), 5'd15, 32'd2);
        expectWrite(27, rWord(FN_ADD, 5'd16, 5'd15, 5'd15), 5'd16, 32'd4);    // Both forwarded.
    endtask

`endif

//--- test/pipeCoreTb.sv
`timescale 1ns/10ps

module pipeCoreTb;

    import isaPkg::*;
    import pipePkg::*;

    localparam int RESET_CYCLES = 16;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    instrU       instr;
    logic [31:0] pc;
    wbT          wbOut;
    redirectT    redirectOut;
    int          cycleCount = 0;

`include "progTable.svh"

    localparam int TIMEOUT_CYCLES = NUM_ROWS + RESET_CYCLES + 8;

    pipeCore pipeCore_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .pc          (pc),
        .wbOut       (wbOut),
        .redirectOut (redirectOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ****************************************
    // Checking
    // ****************************************

    task automatic failRun();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at time %0t: %s expected %h, got %h", $time, name, exp, got);
            failRun();
        end
    endtask

    // Rows outside the table read as idle.
    function automatic rowT rowAt(input int n);
        if (n < 0 || n >= NUM_ROWS) begin
            return '0;
        end
        return prog[n];
    endfunction

    task automatic checkOutputs(input int cyc);
        rowT rdExp;
        rowT wbExp;
        rdExp = rowAt(cyc - 1);
        wbExp = rowAt(cyc - 2);
        compareField("redirectOut.valid", 32'(redirectOut.valid), 32'(rdExp.rdValid));
        if (rdExp.rdValid) begin
            compareField("redirectOut.target", redirectOut.target, rdExp.rdTarget);
        end
        compareField("wbOut.valid", 32'(wbOut.valid), 32'(wbExp.wbValid));
        if (wbExp.wbValid) begin
            compareField("wbOut.destReg", 32'(wbOut.destReg), 32'(wbExp.wbReg));
            compareField("wbOut.data", wbOut.data, wbExp.wbData);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        assert (cycleCount < TIMEOUT_CYCLES) else begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            failRun();
        end
    end

    // ****************************************
    // Stimulus
    // ****************************************

    initial begin
        rowT drv;
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= '0;
        pc         <= '0;
        fillTable();
        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;
        // Two idle cycles first, outputs must stay quiet.
        for (int cyc = -2; cyc < NUM_ROWS + 2; cyc++) begin
            @(posedge clk);
            drv = rowAt(cyc);
            instrValid <= drv.valid;
            instr      <= drv.word;
            pc         <= drv.pc;
            @(negedge clk);
            checkOutputs(cyc);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- src/pipeCore.sv
`timescale 1ns/10ps

module pipeCore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  isaPkg::instrU     instr,
    input  logic [31:0]       pc,
    output pipePkg::wbT       wbOut,
    output pipePkg::redirectT redirectOut
);

    import pipePkg::*;

    ctrlT        ctrl;
    logic [31:0] imm;
    logic [31:0] rsData;
    logic [31:0] rtData;
    idExT        idD;
    idExT        idQ;
    logic        flush;

    // ****************************************
    // Decode stage
    // ****************************************

    instrDecode uDecode (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .rsReg  (instr.r.rs),
        .rtReg  (instr.r.rt),
        .rsData (rsData),
        .rtData (rtData),
        .wr     (wbOut)    // Written from EX/WB.
    );

    assign idD = '{
        valid:   instrValid,
        pcPlus4: pc + 32'd4,
        rsData:  rsData,
        rtData:  rtData,
        imm:     imm,
        rsReg:   instr.r.rs,
        rtReg:   instr.r.rt,
        ctrl:    ctrl
    };

    // ****************************************
    // ID/EX and execute
    // ****************************************

    idExReg uIdEx (
        .clk   (clk),
        .rstN  (rstN),
        .flush (flush),
        .d     (idD),
        .q     (idQ)
    );

    execStage uExec (
        .clk      (clk),
        .rstN     (rstN),
        .idEx     (idQ),
        .flush    (flush),
        .redirect (redirectOut),
        .wb       (wbOut)
    );

endmodule

//--- src/execStage.sv
`timescale 1ns/10ps

module execStage (
    input  logic              clk,
    input  logic              rstN,
    input  pipePkg::idExT     idEx,
    output logic              flush,
    output pipePkg::redirectT redirect,
    output pipePkg::wbT       wb
);

    import pipePkg::*;

    logic        fwdRs;
    logic        fwdRt;
    logic [31:0] opA;
    logic [31:0] rtVal;
    logic [31:0] aluB;
    logic [31:0] result;
    logic        operandsEq;
    logic        taken;
    logic        wbValid;
    logic [4:0]  wbDest;
    logic [31:0] wbData;

    // ****************************************
    // Forwarding from EX/WB
    // ****************************************

    assign fwdRs = wb.valid && (wb.destReg != 5'd0) && (wb.destReg == idEx.rsReg);
    assign fwdRt = wb.valid && (wb.destReg != 5'd0) && (wb.destReg == idEx.rtReg);

    assign opA   = fwdRs ? wb.data : idEx.rsData;
    assign rtVal = fwdRt ? wb.data : idEx.rtData;
    assign aluB  = idEx.ctrl.aluSrcImm ? idEx.imm : rtVal;

    // ****************************************
    // ALU
    // ****************************************

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD: result = opA + aluB;
            ALU_SUB: result = opA - aluB;
            ALU_AND: result = opA & aluB;
            ALU_OR:  result = opA | aluB;
            ALU_SLT: result = {31'd0, $signed(opA) < $signed(aluB)};
            ALU_LUI: result = {aluB[15:0], 16'h0000};
            default: result = opA + aluB;
        endcase
    end

    // ****************************************
    // Branch resolution
    // ****************************************

    assign operandsEq = (opA == rtVal);

    always_comb begin
        case (idEx.ctrl.branch)
            BR_EQ:   taken = idEx.valid && operandsEq;
            BR_NE:   taken = idEx.valid && !operandsEq;
            default: taken = 1'b0;
        endcase
    end

    assign flush           = taken;
    assign redirect.valid  = taken;
    assign redirect.target = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};    // Word offset.

    // ****************************************
    // EX/WB register
    // ****************************************

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= idEx.valid && idEx.ctrl.regWrite && (idEx.ctrl.destReg != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        wbDest <= idEx.ctrl.destReg;
        wbData <= result;
    end

    assign wb = '{valid: wbValid, destReg: wbDest, data: wbData};

endmodule

//--- src/idExReg.sv
`timescale 1ns/10ps

module idExReg (
    input  logic          clk,
    input  logic          rstN,
    input  logic          flush,
    input  pipePkg::idExT d,
    output pipePkg::idExT q
);

    import pipePkg::*;

    // ****************************************
    // ID/EX pipeline register
    // ****************************************

    // A flushed slot loads an all-zero bubble.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= ID_EX_BUBBLE;
        end else if (flush) begin
            q <= ID_EX_BUBBLE;    // Kill the younger instruction.
        end else begin
            q <= d;
        end
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic         clk,
    input  logic         rstN,
    input  logic [4:0]   rsReg,
    input  logic [4:0]   rtReg,
    output logic [31:0]  rsData,
    output logic [31:0]  rtData,
    input  pipePkg::wbT  wr
);

    logic [31:0] regs [32];

    // Register 0 reads zero, a same-cycle write is passed through.
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wr.valid && wr.destReg == addr) begin
            value = wr.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rsData = readPort(rsReg);
        rtData = readPort(rtReg);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.valid && wr.destReg != 5'd0) begin
            regs[wr.destReg] <= wr.data;
        end
    end

endmodule

//--- src/instrDecode.sv
`timescale 1ns/10ps

module instrDecode (
    input  isaPkg::instrU instr,
    output pipePkg::ctrlT ctrl,
    output logic [31:0]   imm
);

    import isaPkg::*;
    import pipePkg::*;

    logic [31:0] immSext;
    logic [31:0] immZext;

    assign immSext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign immZext = {16'h0000, instr.i.imm};

    // ****************************************
    // Control decode
    // ****************************************

    always_comb begin
        ctrl = CTRL_NOP;
        imm  = immSext;
        case (instr.r.opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = instr.r.rd;
                case (instr.r.funct)
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    default: ctrl.regWrite = 1'b0;    // Unknown funct.
                endcase
            end
            OP_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_ADD;
                ctrl.destReg   = instr.i.rt;
            end
            OP_ORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_OR;
                ctrl.destReg   = instr.i.rt;
                imm            = immZext;
            end
            OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_LUI;
                ctrl.destReg   = instr.i.rt;
                imm            = immZext;
            end
            // Branches compare rs against rt, immediate is the word offset.
            OP_BEQ: begin
                ctrl.aluOp  = ALU_SUB;
                ctrl.branch = BR_EQ;
            end
            OP_BNE: begin
                ctrl.aluOp  = ALU_SUB;
                ctrl.branch = BR_NE;
            end
            default: begin
                ctrl = CTRL_NOP;
            end
        endcase
    end

endmodule

//--- src/pipePkg.sv
package pipePkg;

    // ****************************************
    // Control encodings
    // ****************************************

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOpT;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branchT;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrcImm;    // Operand B from the immediate.
        aluOpT      aluOp;
        branchT     branch;
        logic [4:0] destReg;      // Already rd or rt.
    } ctrlT;

    // ****************************************
    // Stage records
    // ****************************************

    typedef struct packed {
        logic        valid;
        logic [31:0] pcPlus4;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;
        logic [4:0]  rsReg;
        logic [4:0]  rtReg;
        ctrlT        ctrl;
    } idExT;

    // EX/WB register and register-file write port.
    typedef struct packed {
        logic        valid;
        logic [4:0]  destReg;
        logic [31:0] data;
    } wbT;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirectT;

    localparam ctrlT CTRL_NOP = '{
        regWrite:  1'b0,
        aluSrcImm: 1'b0,
        aluOp:     ALU_ADD,
        branch:    BR_NONE,
        destReg:   5'd0
    };

    localparam idExT ID_EX_BUBBLE = '0;

endpackage

//--- src/isaPkg.sv
package isaPkg;

    // ****************************************
    // Major opcodes
    // ****************************************

    typedef logic [5:0] opcodeT;

    localparam opcodeT OP_RTYPE = 6'h00;
    localparam opcodeT OP_BEQ   = 6'h04;
    localparam opcodeT OP_BNE   = 6'h05;
    localparam opcodeT OP_ADDI  = 6'h08;
    localparam opcodeT OP_ORI   = 6'h0d;
    localparam opcodeT OP_LUI   = 6'h0f;

    // ****************************************
    // R-type function codes
    // ****************************************

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    // ****************************************
    // Instruction formats
    // ****************************************

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;    // Sign or zero extended by decode.
    } iTypeT;

    // One word, read as either format.
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

endpackage
